/* filelist.f */
+incdir+verilog
verilog/issueSelectPkg.sv
verilog/priorityPick.sv
verilog/cascadedSelectBlock.sv
verilog/oneHotEncoder.sv
verilog/selectTree.sv
verilog/grantRegister.sv
verilog/issueSelect.sv
verification/issueSelect_asserts.sv
verification/issueSelectTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the issue select testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module issueSelectTb -o issueSelectSim

# the testbench itself stops at the first assertion error
simOutput=$(./obj_dir/issueSelectSim +verilator+error+limit+1000 2>&1) || true
echo "$simOutput"

if grep -qx "RESULT: PASS" <<< "$simOutput"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* verification/issueSelectTb.sv */
`timescale 1ns/1ps

/*
 * Testbench for the issue select stage.
 * Drives reset, LFSR-generated and directed request vectors and lane masks;
 * the bound assertion module checks every granted output.
 */
`include "issueSelect_config.svh"

module issueSelectTb import issueSelectPkg::*; ();

	localparam int clkPeriod = 100;
	localparam int resetCycles = 10;
	localparam int randomCycles = 2000;
	localparam int midResetCycles = 3;
	// zero to three requests under each of the eight masks
	localparam int directedCycles = 8 * 4;
	localparam int drainCycles = 4;
	localparam int totalCycles = resetCycles + randomCycles + midResetCycles
		+ directedCycles + drainCycles;
	localparam int watchdogNs = (totalCycles + 50) * clkPeriod;

	logic        clk;
	logic        rstN;
	issueVec_t   requestVector;
	laneMask_t   laneEnable;
	logic        grantedValidA;
	logic        grantedValidB;
	logic        grantedValidC;
	entryIdx_t   grantedEntryA;
	entryIdx_t   grantedEntryB;
	entryIdx_t   grantedEntryC;
	issueVec_t   grantedVectorA;
	issueVec_t   grantedVectorB;
	issueVec_t   grantedVectorC;
	logic [31:0] lfsrState = 32'ha488_25b4;
	int          maskSeen[8] = '{default: 0};
	// cycles with 0, 1, 2 and 3 or more requests
	int          classSeen[4] = '{default: 0};

	issueSelect dut (
		.clk             (clk),
		.rstN_i          (rstN),
		.requestVector_i (requestVector),
		.laneEnable_i    (laneEnable),
		.grantedValidA_o (grantedValidA),
		.grantedValidB_o (grantedValidB),
		.grantedValidC_o (grantedValidC),
		.grantedEntryA_o (grantedEntryA),
		.grantedEntryB_o (grantedEntryB),
		.grantedEntryC_o (grantedEntryC),
		.grantedVectorA_o(grantedVectorA),
		.grantedVectorB_o(grantedVectorB),
		.grantedVectorC_o(grantedVectorC)
	);

	bind issueSelect issueSelectAsserts checks (
		.clk             (clk),
		.rstN_i          (rstN_i),
		.requestVector_i (requestVector_i),
		.laneEnable_i    (laneEnable_i),
		.grantedValidA_i (grantedValidA_o),
		.grantedValidB_i (grantedValidB_o),
		.grantedValidC_i (grantedValidC_o),
		.grantedEntryA_i (grantedEntryA_o),
		.grantedEntryB_i (grantedEntryB_o),
		.grantedEntryC_i (grantedEntryC_o),
		.grantedVectorA_i(grantedVectorA_o),
		.grantedVectorB_i(grantedVectorB_o),
		.grantedVectorC_i(grantedVectorC_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Galois step for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		logic [31:0] shifted;
		shifted = state >> 1;
		if (state[0])
			shifted = shifted ^ 32'h8020_0003;
		return shifted;
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			bits[i] = lfsrState[0];
		end
		return bits;
	endfunction

	// mode 0 is very sparse, mode 3 nearly full
	function automatic issueVec_t randomRequests(input logic [1:0] mode);
		issueVec_t vec;
		for (int i = 0; i < `ISSUEQ_SIZE; i++)
		begin
			case (mode)
				2'd0:    vec[i] = randomBits(4) == 32'd15;
				2'd1:    vec[i] = randomBits(3) == 32'd7;
				2'd2:    vec[i] = randomBits(1) == 32'd1;
				default: vec[i] = randomBits(2) != 32'd0;
			endcase
		end
		return vec;
	endfunction

	// exactly count requests at random positions
	function automatic issueVec_t pickedRequests(input int count);
		issueVec_t   vec;
		logic [31:0] pos;
		vec = '0;
		while ($countones(vec) < count)
		begin
			pos = randomBits(`ISSUEQ_LOG);
			vec[pos[`ISSUEQ_LOG-1:0]] = 1'b1;
		end
		return vec;
	endfunction

	function automatic string coverageGap();
		string gap;
		gap = "";
		foreach (maskSeen[m])
			if (maskSeen[m] == 0)
				gap = $sformatf("lane mask %0d was never driven", m);
		foreach (classSeen[c])
			if (classSeen[c] == 0)
				gap = $sformatf("request count class %0d was never driven", c);
		return gap;
	endfunction

	task automatic abortRun(input string reason);
		$display("RESULT: FAIL");
		$fatal(1, "%s", reason);
	endtask

	task automatic driveCycle(input issueVec_t vec, input laneMask_t mask, input logic rstNext);
		int         reqs;
		logic [1:0] cls;
		@(posedge clk);
		requestVector <= vec;
		laneEnable    <= mask;
		rstN          <= rstNext;
		reqs = $countones(vec);
		cls = (reqs > 3) ? 2'd3 : 2'(reqs);
		// only cycles out of reset count as exercised
		if (rstNext)
		begin
			maskSeen[mask] = maskSeen[mask] + 1;
			classSeen[cls] = classSeen[cls] + 1;
		end
	endtask

	// stop at the first assertion failure
	always @(negedge clk)
	begin
		if (dut.checks.failCount != 0)
			abortRun("an assertion on the grant outputs failed");
	end

	initial
	begin
		#(watchdogNs);
		abortRun("watchdog expired before the stimulus finished");
	end

	initial
	begin
		logic [1:0] mode;
		string      gap;
		rstN <= 1'b0;
		requestVector <= '0;
		laneEnable <= '0;
		// reset is low from time zero, so this makes ten sampled reset cycles
		repeat (resetCycles - 1)
			driveCycle('0, '0, 1'b0);
		for (int n = 0; n < randomCycles; n++)
		begin
			mode = 2'(randomBits(2));
			driveCycle(randomRequests(mode), laneMask_t'(randomBits(3)), 1'b1);
		end
		// reset while requests are pending
		repeat (midResetCycles)
			driveCycle(randomRequests(2'd3), 3'b111, 1'b0);
		for (int m = 0; m < 8; m++)
			for (int k = 0; k <= 3; k++)
				driveCycle(pickedRequests(k), laneMask_t'(m), 1'b1);
		repeat (drainCycles)
			driveCycle('0, '0, 1'b1);
		@(negedge clk);
		gap = coverageGap();
		if (dut.checks.failCount != 0)
			abortRun("an assertion on the grant outputs failed");
		else if (gap != "")
			abortRun(gap);
		else
		begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

/* verification/issueSelect_asserts.sv */
`timescale 1ns/1ps

/*
 * Grant-rule checks for the issue select stage, bound to its top level.
 * Keeps a copy of the inputs seen at the previous edge, works out the expected
 * lane results from them and compares with the registered outputs.
 */
`include "issueSelect_config.svh"

module issueSelectAsserts import issueSelectPkg::*; (
	input logic      clk,
	input logic      rstN_i,
	input issueVec_t requestVector_i,
	input laneMask_t laneEnable_i,
	input logic      grantedValidA_i,
	input logic      grantedValidB_i,
	input logic      grantedValidC_i,
	input entryIdx_t grantedEntryA_i,
	input entryIdx_t grantedEntryB_i,
	input entryIdx_t grantedEntryC_i,
	input issueVec_t grantedVectorA_i,
	input issueVec_t grantedVectorB_i,
	input issueVec_t grantedVectorC_i
);

	// failed checks so far
	int        failCount = 0;
	logic      pastValid = 1'b0;
	logic      prevRst;
	issueVec_t prevReq;
	laneMask_t prevMask;
	laneMask_t grantedValid;
	laneMask_t expValid;
	entryIdx_t lowest1;
	entryIdx_t lowest2;
	entryIdx_t lowest3;
	entryIdx_t expEntryA;
	entryIdx_t expEntryB;
	entryIdx_t expEntryC;
	issueVec_t expVectorA;
	issueVec_t expVectorB;
	issueVec_t expVectorC;
	int        reqCount;
	int        rank;
	int        expCount;

	function automatic entryIdx_t rankedEntry(input int pos, input entryIdx_t first,
			input entryIdx_t second, input entryIdx_t third);
		if (pos == 0)
			return first;
		else if (pos == 1)
			return second;
		return third;
	endfunction

	assign grantedValid = {grantedValidA_i, grantedValidB_i, grantedValidC_i};

	// inputs that produced the outputs now in the register
	always @(posedge clk)
	begin
		pastValid <= 1'b1;
		prevRst   <= rstN_i;
		prevReq   <= requestVector_i;
		prevMask  <= laneEnable_i;
	end

	always_comb
	begin
		reqCount = 0;
		lowest1 = '0;
		lowest2 = '0;
		lowest3 = '0;
		// three lowest requested entries
		for (int i = 0; i < `ISSUEQ_SIZE; i++)
		begin
			if (prevReq[i])
			begin
				if (reqCount == 0)
					lowest1 = entryIdx_t'(i);
				else if (reqCount == 1)
					lowest2 = entryIdx_t'(i);
				else if (reqCount == 2)
					lowest3 = entryIdx_t'(i);
				reqCount = reqCount + 1;
			end
		end
		rank = 0;
		expValid = '0;
		expEntryA = '0;
		expEntryB = '0;
		expEntryC = '0;
		// enabled lanes in order A, B, C take the next entry in rank
		if (prevMask[2])
		begin
			if (rank < reqCount)
			begin
				expValid[2] = 1'b1;
				expEntryA = rankedEntry(rank, lowest1, lowest2, lowest3);
			end
			rank = rank + 1;
		end
		if (prevMask[1])
		begin
			if (rank < reqCount)
			begin
				expValid[1] = 1'b1;
				expEntryB = rankedEntry(rank, lowest1, lowest2, lowest3);
			end
			rank = rank + 1;
		end
		if (prevMask[0])
		begin
			if (rank < reqCount)
			begin
				expValid[0] = 1'b1;
				expEntryC = rankedEntry(rank, lowest1, lowest2, lowest3);
			end
			rank = rank + 1;
		end
		expCount = (reqCount < rank) ? reqCount : rank;
	end

	assign expVectorA = expValid[2] ? (issueVec_t'(1) << expEntryA) : '0;
	assign expVectorB = expValid[1] ? (issueVec_t'(1) << expEntryB) : '0;
	assign expVectorC = expValid[0] ? (issueVec_t'(1) << expEntryC) : '0;

	resetClears: assert property (@(posedge clk) disable iff (!pastValid)
		!prevRst |-> (grantedValid == '0 && grantedEntryA_i == '0 && grantedEntryB_i == '0
			&& grantedEntryC_i == '0 && grantedVectorA_i == '0
			&& grantedVectorB_i == '0 && grantedVectorC_i == '0))
	else
	begin
		failCount = failCount + 1;
		$error("[FAIL] not cleared by reset, grantedValid 0x%h grantedEntry 0x%h 0x%h 0x%h",
			grantedValid, grantedEntryA_i, grantedEntryB_i, grantedEntryC_i);
		$error("[FAIL] not cleared by reset, grantedVector 0x%h 0x%h 0x%h",
			grantedVectorA_i, grantedVectorB_i, grantedVectorC_i);
	end

	laneValid: assert property (@(posedge clk) disable iff (!pastValid)
		prevRst |-> grantedValid == expValid)
	else
	begin
		failCount = failCount + 1;
		$error("[FAIL] grantedValid got 0x%h expected 0x%h", grantedValid, expValid);
	end

	laneAGrant: assert property (@(posedge clk) disable iff (!pastValid)
		prevRst |-> (grantedEntryA_i == expEntryA && grantedVectorA_i == expVectorA))
	else
	begin
		failCount = failCount + 1;
		$error("[FAIL] grantedEntryA_o 0x%h expected 0x%h, grantedVectorA_o 0x%h expected 0x%h",
			grantedEntryA_i, expEntryA, grantedVectorA_i, expVectorA);
	end

	laneBGrant: assert property (@(posedge clk) disable iff (!pastValid)
		prevRst |-> (grantedEntryB_i == expEntryB && grantedVectorB_i == expVectorB))
	else
	begin
		failCount = failCount + 1;
		$error("[FAIL] grantedEntryB_o 0x%h expected 0x%h, grantedVectorB_o 0x%h expected 0x%h",
			grantedEntryB_i, expEntryB, grantedVectorB_i, expVectorB);
	end

	laneCGrant: assert property (@(posedge clk) disable iff (!pastValid)
		prevRst |-> (grantedEntryC_i == expEntryC && grantedVectorC_i == expVectorC))
	else
	begin
		failCount = failCount + 1;
		$error("[FAIL] grantedEntryC_o 0x%h expected 0x%h, grantedVectorC_o 0x%h expected 0x%h",
			grantedEntryC_i, expEntryC, grantedVectorC_i, expVectorC);
	end

	disabledIdle: assert property (@(posedge clk) disable iff (!pastValid)
		prevRst |-> (grantedValid & ~prevMask) == '0)
	else
	begin
		failCount = failCount + 1;
		$error("[FAIL] grantedValid 0x%h on a disabled lane, mask 0x%h", grantedValid, prevMask);
	end

	distinctEntries: assert property (@(posedge clk) disable iff (!pastValid)
		prevRst |-> ((grantedVectorA_i & grantedVectorB_i) == '0
			&& (grantedVectorA_i & grantedVectorC_i) == '0
			&& (grantedVectorB_i & grantedVectorC_i) == '0))
	else
	begin
		failCount = failCount + 1;
		$error("two lanes were granted the same entry");
	end

	validCount: assert property (@(posedge clk) disable iff (!pastValid)
		prevRst |-> $countones(grantedValid) == expCount)
	else
	begin
		failCount = failCount + 1;
		$error("[FAIL] valid lane count 0x%h expected 0x%h", $countones(grantedValid), expCount);
	end

endmodule

/* verilog/cascadedSelectBlock.sv */
`timescale 1ns/1ps

/*
 * Three-lane select block, one node of the select tree.
 * Request groups are interleaved and picked three times in a chain; the enabled
 * lanes take the picks in order A, B, C. Used at the leaves and at the root.
 */
module cascadedSelectBlock #(
	parameter int blockWidth = 8
) (
	input  logic [blockWidth-1:0] reqA_i,
	input  logic [blockWidth-1:0] reqB_i,
	input  logic [blockWidth-1:0] reqC_i,
	input  logic                  grantEnA_i,
	input  logic                  grantEnB_i,
	input  logic                  grantEnC_i,
	output logic [blockWidth-1:0] grantA_o,
	output logic [blockWidth-1:0] grantB_o,
	output logic [blockWidth-1:0] grantC_o,
	output logic                  reqA_o,
	output logic                  reqB_o,
	output logic                  reqC_o
);

	localparam int fullWidth = 3 * blockWidth;

	logic [fullWidth-1:0]  stage1Vec;
	logic [fullWidth-1:0]  stage2Vec;
	logic [fullWidth-1:0]  stage3Vec;
	logic [fullWidth-1:0]  pick1Vec;
	logic [fullWidth-1:0]  pick2Vec;
	logic [fullWidth-1:0]  pick3Vec;
	logic [blockWidth-1:0] pick1Grp;
	logic [blockWidth-1:0] pick2Grp;
	logic [blockWidth-1:0] pick3Grp;

	// input i occupies three adjacent bits, A lowest
	always_comb
	begin
		for (int i = 0; i < blockWidth; i++)
		begin
			stage1Vec[3*i]   = reqA_i[i];
			stage1Vec[3*i+1] = reqB_i[i];
			stage1Vec[3*i+2] = reqC_i[i];
		end
	end

	// each pick only sees what the earlier picks left
	assign stage2Vec = stage1Vec & ~pick1Vec;
	assign stage3Vec = stage2Vec & ~pick2Vec;

	priorityPick #(.pickWidth(fullWidth)) firstPick (
		.pickIn_i (stage1Vec),
		.pickOut_o(pick1Vec)
	);

	priorityPick #(.pickWidth(fullWidth)) secondPick (
		.pickIn_i (stage2Vec),
		.pickOut_o(pick2Vec)
	);

	priorityPick #(.pickWidth(fullWidth)) thirdPick (
		.pickIn_i (stage3Vec),
		.pickOut_o(pick3Vec)
	);

	// fold each pick back to one bit per input
	always_comb
	begin
		for (int i = 0; i < blockWidth; i++)
		begin
			pick1Grp[i] = |pick1Vec[3*i +: 3];
			pick2Grp[i] = |pick2Vec[3*i +: 3];
			pick3Grp[i] = |pick3Vec[3*i +: 3];
		end
	end

	// counts seen by the next level up
	assign reqA_o = |pick1Vec;
	assign reqB_o = |pick2Vec;
	assign reqC_o = |pick3Vec;

	// enabled lanes take the next unused pick, disabled lanes get nothing
	always_comb
	begin
		grantA_o = '0;
		grantB_o = '0;
		grantC_o = '0;
		if (grantEnA_i)
			grantA_o = pick1Grp;
		if (grantEnB_i)
			grantB_o = grantEnA_i ? pick2Grp : pick1Grp;
		if (grantEnC_i)
		begin
			case ({grantEnA_i, grantEnB_i})
				2'b00:   grantC_o = pick1Grp;
				2'b11:   grantC_o = pick3Grp;
				default: grantC_o = pick2Grp;
			endcase
		end
	end

endmodule

/* verilog/grantRegister.sv */
`timescale 1ns/1ps

/*
 * Output register of the select stage.
 * Captures each lane's grant vector and index every cycle and derives the lane
 * valid from a nonzero grant. Synchronous active-low reset clears all outputs.
 */
module grantRegister import issueSelectPkg::*; (
	input  logic      clk,
	input  logic      rstN_i,
	input  issueVec_t grantVecA_i,
	input  issueVec_t grantVecB_i,
	input  issueVec_t grantVecC_i,
	input  entryIdx_t entryA_i,
	input  entryIdx_t entryB_i,
	input  entryIdx_t entryC_i,
	output logic      grantedValidA_o,
	output logic      grantedValidB_o,
	output logic      grantedValidC_o,
	output entryIdx_t grantedEntryA_o,
	output entryIdx_t grantedEntryB_o,
	output entryIdx_t grantedEntryC_o,
	output issueVec_t grantedVectorA_o,
	output issueVec_t grantedVectorB_o,
	output issueVec_t grantedVectorC_o
);

	always_ff @(posedge clk)
	begin
		if (!rstN_i)
		begin
			grantedValidA_o  <= 1'b0;
			grantedValidB_o  <= 1'b0;
			grantedValidC_o  <= 1'b0;
			grantedEntryA_o  <= '0;
			grantedEntryB_o  <= '0;
			grantedEntryC_o  <= '0;
			grantedVectorA_o <= '0;
			grantedVectorB_o <= '0;
			grantedVectorC_o <= '0;
		end
		else
		begin
			// a lane is valid only when it actually got an entry
			grantedValidA_o  <= |grantVecA_i;
			grantedValidB_o  <= |grantVecB_i;
			grantedValidC_o  <= |grantVecC_i;
			grantedEntryA_o  <= entryA_i;
			grantedEntryB_o  <= entryB_i;
			grantedEntryC_o  <= entryC_i;
			grantedVectorA_o <= grantVecA_i;
			grantedVectorB_o <= grantVecB_i;
			grantedVectorC_o <= grantVecC_i;
		end
	end

endmodule

/* verilog/issueSelect.sv */
`timescale 1ns/1ps

/*
 * Top level of the three-lane issue select stage.
 * Takes a request vector and lane enables every cycle; grants, indices and
 * valids for those inputs appear one clock edge later.
 */
module issueSelect import issueSelectPkg::*; (
	input  logic      clk,
	input  logic      rstN_i,
	input  issueVec_t requestVector_i,
	input  laneMask_t laneEnable_i,
	output logic      grantedValidA_o,
	output logic      grantedValidB_o,
	output logic      grantedValidC_o,
	output entryIdx_t grantedEntryA_o,
	output entryIdx_t grantedEntryB_o,
	output entryIdx_t grantedEntryC_o,
	output issueVec_t grantedVectorA_o,
	output issueVec_t grantedVectorB_o,
	output issueVec_t grantedVectorC_o
);

	// combinational grants for the current request vector
	issueVec_t grantVecA;
	issueVec_t grantVecB;
	issueVec_t grantVecC;
	entryIdx_t entryA;
	entryIdx_t entryB;
	entryIdx_t entryC;

	selectTree tree (
		.requestVector_i(requestVector_i),
		.laneEnable_i   (laneEnable_i),
		.grantVecA_o    (grantVecA),
		.grantVecB_o    (grantVecB),
		.grantVecC_o    (grantVecC)
	);

	oneHotEncoder encodeA (
		.vector_i (grantVecA),
		.encoded_o(entryA)
	);

	oneHotEncoder encodeB (
		.vector_i (grantVecB),
		.encoded_o(entryB)
	);

	oneHotEncoder encodeC (
		.vector_i (grantVecC),
		.encoded_o(entryC)
	);

	grantRegister outReg (
		.clk             (clk),
		.rstN_i          (rstN_i),
		.grantVecA_i     (grantVecA),
		.grantVecB_i     (grantVecB),
		.grantVecC_i     (grantVecC),
		.entryA_i        (entryA),
		.entryB_i        (entryB),
		.entryC_i        (entryC),
		.grantedValidA_o (grantedValidA_o),
		.grantedValidB_o (grantedValidB_o),
		.grantedValidC_o (grantedValidC_o),
		.grantedEntryA_o (grantedEntryA_o),
		.grantedEntryB_o (grantedEntryB_o),
		.grantedEntryC_o (grantedEntryC_o),
		.grantedVectorA_o(grantedVectorA_o),
		.grantedVectorB_o(grantedVectorB_o),
		.grantedVectorC_o(grantedVectorC_o)
	);

endmodule

/* verilog/issueSelectPkg.sv */
/*
 * Vector types shared by the select stage.
 * Modules import this package in their header; widths come from the config defines.
 */
`include "issueSelect_config.svh"

package issueSelectPkg;

	// one bit per queue entry, used for requests and one-hot grants
	typedef logic [`ISSUEQ_SIZE-1:0] issueVec_t;

	// encoded entry number
	typedef logic [`ISSUEQ_LOG-1:0] entryIdx_t;

	// lane enables, bit 2 is lane A, bit 1 lane B, bit 0 lane C
	typedef logic [`ISSUE_LANES-1:0] laneMask_t;

endpackage

/* verilog/issueSelect_config.svh */
/*
 * Sizing constants for the issue-queue select stage.
 * Include this header wherever the queue, index or tree dimensions are needed;
 * the leaf width times the leaf count must equal the queue size.
 */
`ifndef ISSUESELECT_CONFIG_SVH
`define ISSUESELECT_CONFIG_SVH

// queue entries, one request bit each
`define ISSUEQ_SIZE 32
// bits of an encoded entry number
`define ISSUEQ_LOG 5
// issue lanes A, B and C
`define ISSUE_LANES 3
// entries handled by one leaf of the select tree
`define SELECT_LEAF_WIDTH 8
// leaves under the root, also the root input width
`define SELECT_LEAF_COUNT 4

`endif

/* verilog/oneHotEncoder.sv */
`timescale 1ns/1ps

/*
 * One-hot to index encoder for a lane's grant vector.
 * ORs the positions of all set bits; a zero vector encodes to entry 0.
 */
`include "issueSelect_config.svh"

module oneHotEncoder import issueSelectPkg::*; (
	input  issueVec_t vector_i,
	output entryIdx_t encoded_o
);

	always_comb
	begin
		encoded_o = '0;
		for (int i = 0; i < `ISSUEQ_SIZE; i++)
		begin
			// only one bit is expected, so the OR is that bit's position
			if (vector_i[i])
				encoded_o = encoded_o | entryIdx_t'(i);
		end
	end

endmodule

/* verilog/priorityPick.sv */
`timescale 1ns/1ps

/*
 * Lowest-set-bit picker.
 * Clears every bit above the lowest set bit, so the output is zero or one-hot.
 */
module priorityPick #(
	parameter int pickWidth = 24
) (
	input  logic [pickWidth-1:0] pickIn_i,
	output logic [pickWidth-1:0] pickOut_o
);

	// a bit stays open only while nothing below it was set
	logic [pickWidth-1:0] keepMask;

	always_comb
	begin
		keepMask[0] = 1'b1;
		for (int j = 1; j < pickWidth; j++)
		begin
			if (pickIn_i[j-1])
				keepMask[j] = 1'b0;
			else
				keepMask[j] = keepMask[j-1];
		end
	end

	assign pickOut_o = pickIn_i & keepMask;

endmodule

/* verilog/selectTree.sv */
`timescale 1ns/1ps

/*
 * Two-level, three-lane select tree over the whole issue queue.
 * Four leaves report how many requests they hold; the root hands the lane
 * enables down so each lane lands on the right entry of the right leaf.
 */
`include "issueSelect_config.svh"

module selectTree import issueSelectPkg::*; (
	input  issueVec_t requestVector_i,
	input  laneMask_t laneEnable_i,
	output issueVec_t grantVecA_o,
	output issueVec_t grantVecB_o,
	output issueVec_t grantVecC_o
);

	// leaf holds at least one, two, three requests
	logic [`SELECT_LEAF_COUNT-1:0] leafAtLeast1;
	logic [`SELECT_LEAF_COUNT-1:0] leafAtLeast2;
	logic [`SELECT_LEAF_COUNT-1:0] leafAtLeast3;

	// per-leaf lane enables from the root
	logic [`SELECT_LEAF_COUNT-1:0] leafEnA;
	logic [`SELECT_LEAF_COUNT-1:0] leafEnB;
	logic [`SELECT_LEAF_COUNT-1:0] leafEnC;

	for (genvar leaf = 0; leaf < `SELECT_LEAF_COUNT; leaf++)
	begin : gLeaf
		// leaves only carry queue requests on their A inputs
		cascadedSelectBlock #(.blockWidth(`SELECT_LEAF_WIDTH)) leafBlock (
			.reqA_i    (requestVector_i[leaf*`SELECT_LEAF_WIDTH +: `SELECT_LEAF_WIDTH]),
			.reqB_i    ('0),
			.reqC_i    ('0),
			.grantEnA_i(leafEnA[leaf]),
			.grantEnB_i(leafEnB[leaf]),
			.grantEnC_i(leafEnC[leaf]),
			.grantA_o  (grantVecA_o[leaf*`SELECT_LEAF_WIDTH +: `SELECT_LEAF_WIDTH]),
			.grantB_o  (grantVecB_o[leaf*`SELECT_LEAF_WIDTH +: `SELECT_LEAF_WIDTH]),
			.grantC_o  (grantVecC_o[leaf*`SELECT_LEAF_WIDTH +: `SELECT_LEAF_WIDTH]),
			.reqA_o    (leafAtLeast1[leaf]),
			.reqB_o    (leafAtLeast2[leaf]),
			.reqC_o    (leafAtLeast3[leaf])
		);
	end

	// root interleaves the counts per leaf, so a busy leaf can absorb
	// several lanes before the next leaf is considered
	// lane valid is taken from the grant vectors, the root counts stay open
	cascadedSelectBlock #(.blockWidth(`SELECT_LEAF_COUNT)) rootBlock (
		.reqA_i    (leafAtLeast1),
		.reqB_i    (leafAtLeast2),
		.reqC_i    (leafAtLeast3),
		.grantEnA_i(laneEnable_i[2]),
		.grantEnB_i(laneEnable_i[1]),
		.grantEnC_i(laneEnable_i[0]),
		.grantA_o  (leafEnA),
		.grantB_o  (leafEnB),
		.grantC_o  (leafEnC),
		.reqA_o    (),
		.reqB_o    (),
		.reqC_o    ()
	);

endmodule
